// ==== src/fpu_rnd_pkg.sv ====
//////////////////////////////
// shared widths, types and constants for the fp32 rounding back end
// exponents are 10-bit biased, with room for overflow above 254
// input fraction has a carry bit at 27, round and sticky at the bottom
// special-value patterns are 31-bit magnitudes, the sign is added at pack
//////////////////////////////

package fpu_rnd_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int EXP_W      = 10;  // internal exponent
  localparam int FRACT_IN_W = 28;  // carry + 24 significand + g/r/s
  localparam int FRACT_W    = 32;  // aligned fraction
  localparam int SHIFT_W    = 5;   // shift amount

  localparam logic [EXP_W-1:0] EXP_MAX = EXP_W'(254); // largest finite biased exp

  //////////////////////////////
  // special output magnitudes
  //////////////////////////////
  localparam logic [30:0] INF_PAT  = 31'h7f80_0000;
  localparam logic [30:0] QNAN_PAT = 31'h7fc0_0000;
  localparam logic [30:0] SNAN_PAT = 31'h7fbf_ffff; // invalid-op result

  // rounding modes, same encoding as the fpcsr rm field
  typedef enum logic [1:0] {
    RM_NEAREST = 2'b00,
    RM_TO_ZERO = 2'b01,
    RM_TO_INFP = 2'b10,
    RM_TO_INFM = 2'b11
  } rmode_e;

  // special-operand info from the arithmetic unit
  typedef struct packed {
    logic inv;        // invalid operation
    logic inf;        // infinity operand
    logic snan;       // signalling nan operand
    logic qnan;       // quiet nan operand
    logic anan_sign;  // sign for a nan result
  } special_t;

  // source item, one arithmetic result before alignment
  typedef struct packed {
    logic                  sign;
    logic [SHIFT_W-1:0]    shr;       // right shift request
    logic [EXP_W-1:0]      exp10shr;  // exponent if right shifted
    logic                  shl;       // left shift by one
    logic [EXP_W-1:0]      exp10shl;  // exponent if left shifted
    logic [EXP_W-1:0]      exp10sh0;  // exponent if not shifted
    logic [FRACT_IN_W-1:0] fract28;
    special_t              special;
  } arith_src_t;

  // align -> round
  typedef struct packed {
    logic               sign;
    logic [EXP_W-1:0]   exp10;
    logic [FRACT_W-1:0] fract32;
    logic [1:0]         rs;       // round, sticky
    special_t           special;
  } align_out_t;

  // round -> pack
  typedef struct packed {
    logic               sign;
    logic [EXP_W-1:0]   exp10;
    logic [FRACT_W-1:0] fract32;  // already incremented
    logic               lost;     // any bit dropped
    special_t           special;
  } round_out_t;

  // exception flags
  typedef struct packed {
    logic ovf;
    logic unf;
    logic snf;
    logic qnf;
    logic zf;
    logic ixf;
    logic ivf;
    logic inf;
  } fpcsr_t;

endpackage

// ==== src/fpu_align.sv ====
//////////////////////////////
// stage 1, source capture and alignment
// caller must not request shr and shl on the same item
// shl shifts left by at most one bit
// holds everything while adv_i is low
//////////////////////////////

`timescale 1ns/1ns

module fpu_align (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    adv_i,
  input  logic                    flush_i,
  input  logic                    src_valid_i,
  input  fpu_rnd_pkg::arith_src_t src_i,
  output logic                    s1_valid_o,
  output fpu_rnd_pkg::align_out_t s1_o
);

  import fpu_rnd_pkg::*;

  localparam int WIDE_W = FRACT_W + 3; // result plus g/r/s slots

  logic               carry;       // fract28 overflowed into bit 27
  logic [SHIFT_W-1:0] shr_eff;
  logic               do_shr;
  logic [WIDE_W-1:0]  fract_wide;
  logic [WIDE_W-1:0]  fract_sh;
  logic               sticky_r;
  logic               sticky_l;
  logic               sticky;
  logic [EXP_W-1:0]   exp_sel;

  //////////////////////////////
  // shift
  //////////////////////////////
  assign carry      = src_i.fract28[FRACT_IN_W-1];
  assign shr_eff    = (|src_i.shr) ? src_i.shr : {{(SHIFT_W-1){1'b0}}, carry};
  assign do_shr     = |shr_eff;
  assign fract_wide = {{(WIDE_W-FRACT_IN_W){1'b0}}, src_i.fract28};

  assign fract_sh = do_shr ? (fract_wide >> shr_eff)
                           : (fract_wide << src_i.shl);

  // right shift: or of everything that falls below the round bit
  always_comb begin
    sticky_r = 1'b0;
    for (int i = 0; i < WIDE_W; i++) begin
      if (i <= int'(shr_eff) + 1)
        sticky_r = sticky_r | fract_wide[i];
    end
  end

  // left shift keeps the low input bit as sticky
  assign sticky_l = src_i.shl ? fract_wide[0] : |fract_wide[1:0];
  assign sticky   = do_shr ? sticky_r : sticky_l;

  //////////////////////////////
  // exponent select
  //////////////////////////////
  always_comb begin
    if (|src_i.shr)
      exp_sel = src_i.exp10shr;
    else if (carry)
      exp_sel = src_i.exp10sh0 + EXP_W'(1); // renorm by one
    else if (src_i.shl)
      exp_sel = src_i.exp10shl;
    else
      exp_sel = src_i.exp10sh0;              // add path, no shift
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_o.sign    <= src_i.sign;
      s1_o.exp10   <= exp_sel;
      s1_o.fract32 <= fract_sh[WIDE_W-1:3];
      s1_o.rs      <= {fract_sh[2], sticky};
      s1_o.special <= src_i.special;
    end
  end

  // valid
  always_ff @(posedge clk) begin
    if (rst)
      s1_valid_o <= 1'b0;
    else if (flush_i)
      s1_valid_o <= 1'b0;     // drop in-flight item
    else if (adv_i)
      s1_valid_o <= src_valid_i;
  end

  // upstream contract, one direction per item
  a_one_shift_dir : assert property (
    @(posedge clk) disable iff (rst)
    (adv_i && src_valid_i) |-> !((|src_i.shr) && src_i.shl)
  );

endmodule

// ==== src/fpu_round.sv ====
//////////////////////////////
// stage 2, rounding decision and increment
// rmode_i is not pipelined, hold it while items are in flight
// renormalization after carry is left to pack
//////////////////////////////

`timescale 1ns/1ns

module fpu_round (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    adv_i,
  input  logic                    flush_i,
  input  fpu_rnd_pkg::rmode_e     rmode_i,
  input  logic                    s1_valid_i,
  input  fpu_rnd_pkg::align_out_t s1_i,
  output logic                    s2_valid_o,
  output fpu_rnd_pkg::round_out_t s2_o
);

  import fpu_rnd_pkg::*;

  logic guard_bit;  // lsb of kept fraction
  logic rnd_bit;
  logic stk_bit;
  logic lost;
  logic rnd_up;

  assign guard_bit = s1_i.fract32[0];
  assign rnd_bit   = s1_i.rs[1];
  assign stk_bit   = s1_i.rs[0];
  assign lost      = rnd_bit | stk_bit;

  always_comb begin
    case (rmode_i)
      RM_NEAREST: rnd_up = (rnd_bit & stk_bit) |
                           (rnd_bit & ~stk_bit & guard_bit); // tie to even
      RM_TO_INFP: rnd_up = ~s1_i.sign & lost;
      RM_TO_INFM: rnd_up =  s1_i.sign & lost;
      default:    rnd_up = 1'b0;  // truncate
    endcase
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s2_o.sign    <= s1_i.sign;
      s2_o.exp10   <= s1_i.exp10;
      s2_o.fract32 <= s1_i.fract32 + {{(FRACT_W-1){1'b0}}, rnd_up}; // may carry to bit 24
      s2_o.lost    <= lost;
      s2_o.special <= s1_i.special;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      s2_valid_o <= 1'b0;
    else if (flush_i)
      s2_valid_o <= 1'b0;
    else if (adv_i)
      s2_valid_o <= s1_valid_i;
  end

  // valid chain stays clean once out of reset
  a_valid_known : assert property (
    @(posedge clk) disable iff (rst) !$isunknown(s2_valid_o)
  );

endmodule

// ==== src/fpu_pack.sv ====
//////////////////////////////
// stage 3, renormalize, pick special cases, pack fp32
// nan inputs take priority over invalid, then infinity, then denormal
// exact overflow leaves ixf clear
// outputs hold while adv_i is low, reset and flush clear them
//////////////////////////////

`timescale 1ns/1ns

module fpu_pack (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    adv_i,
  input  logic                    flush_i,
  input  logic                    s2_valid_i,
  input  fpu_rnd_pkg::round_out_t s2_i,
  output logic [31:0]             result_o,
  output logic                    result_valid_o,
  output fpu_rnd_pkg::fpcsr_t     fpcsr_o
);

  import fpu_rnd_pkg::*;

  logic             rnd_carry;   // rounding overflowed to bit 24
  logic [EXP_W-1:0] exp_fin;
  logic [23:0]      fract24;
  logic             is_dn;       // hidden bit clear
  logic             is_zero;
  logic [31:0]      result_d;
  fpcsr_t           flags_d;

  //////////////////////////////
  // renormalize
  //////////////////////////////
  assign rnd_carry = s2_i.fract32[24];
  assign exp_fin   = s2_i.exp10 + {{(EXP_W-1){1'b0}}, rnd_carry};
  assign fract24   = rnd_carry ? s2_i.fract32[24:1] : s2_i.fract32[23:0];
  assign is_dn     = ~fract24[23];
  assign is_zero   = ~(|fract24);

  //////////////////////////////
  // result select
  //////////////////////////////
  always_comb begin
    flags_d = '0;
    if (s2_i.special.snan || s2_i.special.qnan) begin
      result_d    = {s2_i.special.anan_sign, QNAN_PAT};
      flags_d.qnf = 1'b1;
      flags_d.snf = s2_i.special.snan;
    end else if (s2_i.special.inv) begin
      result_d    = {s2_i.sign, SNAN_PAT};  // invalid pattern
      flags_d.snf = 1'b1;
      flags_d.ivf = 1'b1;
    end else if (s2_i.special.inf || (exp_fin > EXP_MAX)) begin
      result_d    = {s2_i.sign, INF_PAT};
      flags_d.inf = 1'b1;
      flags_d.ovf = ~s2_i.special.inf;                // computed overflow only
      flags_d.ixf = ~s2_i.special.inf & s2_i.lost;
    end else if (is_dn) begin
      result_d    = {s2_i.sign, 8'd0, fract24[22:0]}; // denormal or zero
      flags_d.zf  = is_zero;
      flags_d.unf = s2_i.lost;
      flags_d.ixf = s2_i.lost;
    end else begin
      result_d    = {s2_i.sign, exp_fin[7:0], fract24[22:0]};
      flags_d.ixf = s2_i.lost;
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      result_o       <= '0;
      result_valid_o <= 1'b0;
      fpcsr_o        <= '0;
    end else if (adv_i) begin
      result_o       <= result_d;
      result_valid_o <= s2_valid_i;
      fpcsr_o        <= flags_d;
    end
  end

  // overflow and underflow are exclusive outcomes
  a_ovf_unf_excl : assert property (
    @(posedge clk) disable iff (rst) !(fpcsr_o.ovf && fpcsr_o.unf)
  );

endmodule

// ==== src/fpu_rnd_top.sv ====
//////////////////////////////
// fp32 rounding back end, align -> round -> pack
// three advances of latency, one item per stage
// no ready output, upstream follows adv_i
//////////////////////////////

`timescale 1ns/1ns

module fpu_rnd_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    adv_i,    // advance all stages
  input  logic                    flush_i,  // drop everything in flight
  input  fpu_rnd_pkg::rmode_e     rmode_i,
  input  logic                    src_valid_i,
  input  fpu_rnd_pkg::arith_src_t src_i,
  output logic [31:0]             result_o,
  output logic                    result_valid_o,
  output fpu_rnd_pkg::fpcsr_t     fpcsr_o
);

  import fpu_rnd_pkg::*;

  logic       s1_valid;
  align_out_t s1;
  logic       s2_valid;
  round_out_t s2;

  fpu_align fpu_align_inst (
    .clk         (clk),
    .rst         (rst),
    .adv_i       (adv_i),
    .flush_i     (flush_i),
    .src_valid_i (src_valid_i),
    .src_i       (src_i),
    .s1_valid_o  (s1_valid),
    .s1_o        (s1)
  );

  fpu_round fpu_round_inst (
    .clk        (clk),
    .rst        (rst),
    .adv_i      (adv_i),
    .flush_i    (flush_i),
    .rmode_i    (rmode_i),
    .s1_valid_i (s1_valid),
    .s1_i       (s1),
    .s2_valid_o (s2_valid),
    .s2_o       (s2)
  );

  fpu_pack fpu_pack_inst (
    .clk            (clk),
    .rst            (rst),
    .adv_i          (adv_i),
    .flush_i        (flush_i),
    .s2_valid_i     (s2_valid),
    .s2_i           (s2),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .fpcsr_o        (fpcsr_o)
  );

endmodule

// ==== bench/fpu_rnd_tb.sv ====
//////////////////////////////
// testbench for the fp32 rounding back end
// cases come from bench/fpu_rnd_cases.txt, run from the project root
// adv_i stalls at random, rmode changes and flushes wait for an empty pipe
// at most two flushed cases in a row, a third would reach the output
//////////////////////////////

`timescale 1ns/1ns

module fpu_rnd_tb;

  import fpu_rnd_pkg::*;

  localparam int          MAX_CASES = 64;
  localparam logic [31:0] SEED      = 32'h9b77_0b95;
  localparam string       CASE_FILE = "bench/fpu_rnd_cases.txt";

  logic        clk = 1'b0;
  logic        rst;
  logic        adv_i;
  logic        flush_i;
  rmode_e      rmode_i;
  logic        src_valid_i;
  arith_src_t  src_i;
  logic [31:0] result_o;
  logic        result_valid_o;
  fpcsr_t      fpcsr_o;

  // case table, filled from the file
  string       case_lbl   [MAX_CASES];
  rmode_e      case_rm    [MAX_CASES];
  arith_src_t  case_src   [MAX_CASES];
  logic        case_fl    [MAX_CASES];  // dropped by a flush
  logic [31:0] case_res   [MAX_CASES];
  logic [7:0]  case_flags [MAX_CASES];
  int          n_cases = 0;

  int   pend_q [$];          // expected results, oldest first
  int   fl_q   [$];          // cases waiting for their flush
  logic flush_pend   = 1'b0;
  int   idx          = 0;    // next case to issue
  int   err_cnt      = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  int   cycle_cnt    = 0;
  int   cycle_limit  = 100;

  // outputs seen at the previous negedge, for the stall hold check
  logic [31:0] last_res = '0;
  logic        last_vld = 1'b0;
  fpcsr_t      last_flg = '0;

  fpu_rnd_top fpu_rnd_top_inst (
    .clk            (clk),
    .rst            (rst),
    .adv_i          (adv_i),
    .flush_i        (flush_i),
    .rmode_i        (rmode_i),
    .src_valid_i    (src_valid_i),
    .src_i          (src_i),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .fpcsr_o        (fpcsr_o)
  );

  always #5 clk = ~clk;  // 10 ns

  // watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, results stopped arriving", cycle_cnt);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int k, input logic ok);
    tests_run++;
    if (!ok)
      tests_failed++;
    $display("test %s %s", case_lbl[k], ok ? "ok" : "failed");
  endtask

  task automatic load_cases();
    int          fd;
    int          nf;
    string       line;
    string       lbl;
    logic [31:0] f_rm;
    logic [31:0] f_sg;
    logic [31:0] f_shr;
    logic [31:0] f_eshr;
    logic [31:0] f_shl;
    logic [31:0] f_eshl;
    logic [31:0] f_esh0;
    logic [31:0] f_fr;
    logic [31:0] f_sp;
    logic [31:0] f_fl;
    logic [31:0] f_res;
    logic [31:0] f_flg;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the case file %s", CASE_FILE);
      err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#")
          continue;                               // blank or column notes
        nf = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", lbl, f_rm, f_sg,
                     f_shr, f_eshr, f_shl, f_eshl, f_esh0, f_fr, f_sp, f_fl, f_res, f_flg);
        if (nf != 13) begin
          $display("Case file line could not be read: %s", line);
          err_cnt++;
        end else if (n_cases == MAX_CASES) begin
          $display("Too many cases in the file, the rest are skipped");
          err_cnt++;
        end else begin
          case_lbl[n_cases]          = lbl;
          case_rm[n_cases]           = rmode_e'(f_rm[1:0]);
          case_src[n_cases].sign     = f_sg[0];
          case_src[n_cases].shr      = f_shr[SHIFT_W-1:0];
          case_src[n_cases].exp10shr = f_eshr[EXP_W-1:0];
          case_src[n_cases].shl      = f_shl[0];
          case_src[n_cases].exp10shl = f_eshl[EXP_W-1:0];
          case_src[n_cases].exp10sh0 = f_esh0[EXP_W-1:0];
          case_src[n_cases].fract28  = f_fr[FRACT_IN_W-1:0];
          case_src[n_cases].special  = special_t'(f_sp[4:0]);
          case_fl[n_cases]           = f_fl[0];
          case_res[n_cases]          = f_res;
          case_flags[n_cases]        = f_flg[7:0];
          n_cases++;
        end
      end
      $fclose(fd);
    end
    if (n_cases == 0)
      $display("No test cases were read");
  endtask

  // outputs as left by the last rising edge
  task automatic check_outputs();
    int k;
    int errs_before;
    errs_before = err_cnt;
    if (flush_i) begin
      check_value("result_valid_o", 32'd0, {31'd0, result_valid_o});
      check_value("result_o", 32'd0, result_o);
      check_value("fpcsr_o", 32'd0, {24'd0, fpcsr_o});
      while (fl_q.size() != 0) begin
        k = fl_q.pop_front();
        report_test(k, err_cnt == errs_before);
      end
    end else if (adv_i && result_valid_o) begin
      if (pend_q.size() == 0) begin
        $display("Unexpected result at %0t ns with no test in flight", $time);
        err_cnt++;
      end else begin
        k = pend_q.pop_front();
        check_value("result_o", case_res[k], result_o);
        check_value("fpcsr_o", {24'd0, case_flags[k]}, {24'd0, fpcsr_o});
        report_test(k, err_cnt == errs_before);
      end
    end else if (!adv_i) begin
      // stalled edge, outputs must hold
      check_value("result_valid_o", {31'd0, last_vld}, {31'd0, result_valid_o});
      check_value("result_o", last_res, result_o);
      check_value("fpcsr_o", {24'd0, last_flg}, {24'd0, fpcsr_o});
    end
    last_res = result_o;
    last_vld = result_valid_o;
    last_flg = fpcsr_o;
  endtask

  task automatic drive_inputs();
    logic need_empty;
    flush_i     = 1'b0;
    src_valid_i = 1'b0;
    adv_i       = ($urandom % 32'd4) != 32'd0;  // stall about one cycle in four
    if (flush_pend) begin
      flush_i    = 1'b1;
      flush_pend = 1'b0;
    end else if (idx < n_cases) begin
      // rmode is not pipelined, a flush must not hit older cases
      need_empty = (case_rm[idx] != rmode_i) ||
                   (case_fl[idx] && (idx == 0 || !case_fl[idx-1]));
      if (adv_i && !(need_empty && pend_q.size() != 0)) begin
        rmode_i     = case_rm[idx];
        src_valid_i = 1'b1;
        src_i       = case_src[idx];
        if (case_fl[idx]) begin
          fl_q.push_back(idx);
          if (idx + 1 == n_cases || !case_fl[idx+1])
            flush_pend = 1'b1;                    // flush on the next cycle
        end else begin
          pend_q.push_back(idx);
        end
        idx++;
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    rst         = 1'b1;
    adv_i       = 1'b0;
    flush_i     = 1'b0;
    rmode_i     = RM_NEAREST;
    src_valid_i = 1'b0;
    src_i       = '0;
    void'($urandom(SEED));
    load_cases();
    cycle_limit = 4 * n_cases + 100;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (!(idx == n_cases && pend_q.size() == 0 && fl_q.size() == 0 && !flush_pend)) begin
      @(negedge clk);
      check_outputs();
      drive_inputs();
    end
    $display("%0d of %0d tests run, %0d failed, %0d mismatches",
             tests_run, n_cases, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_run == n_cases && n_cases > 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== bench/fpu_rnd_cases.txt ====
# label rm sign shr exp_shr shl exp_shl exp_sh0 fract28 special flush result flags, all hex
# special = {inv,inf,snan,qnan,anan_sign}, flags = {ovf,unf,snf,qnf,zf,ixf,ivf,inf}
norm_one        0 0 00 000 0 000 07f 4000000 00 0 3f800000 00
norm_neg3       0 1 00 000 0 000 080 6000000 00 0 c0400000 00
norm_pi         0 0 00 000 0 000 080 6487ed8 00 0 40490fdb 00
norm_max        0 0 00 000 0 000 0fe 7fffff8 00 0 7f7fffff 00
right_carry     0 0 01 080 0 000 000 8000000 00 0 40000000 00
carry_renorm    0 0 00 000 0 000 07f c000000 00 0 40400000 00
left_shift      0 0 00 000 1 081 000 3000000 00 0 40c00000 00
rne_tie_even    0 0 00 000 0 000 07f 4000004 00 0 3f800000 04
rne_tie_odd     0 0 00 000 0 000 07f 400000c 00 0 3f800002 04
rne_above       0 0 00 000 0 000 07f 4000006 00 0 3f800001 04
rne_below       0 0 00 000 0 000 07f 4000003 00 0 3f800000 04
rne_neg_above   0 1 00 000 0 000 07f 4000006 00 0 bf800001 04
rne_exp_carry   0 0 00 000 0 000 07f 7fffffc 00 0 40000000 04
ovf_inexact     0 0 00 000 0 000 0ff 4000004 00 0 7f800000 85
ovf_neg         0 1 00 000 0 000 0ff 4000004 00 0 ff800000 85
ovf_by_round    0 0 00 000 0 000 0fe 7fffffc 00 0 7f800000 85
ovf_exact       0 0 00 000 0 000 100 4000000 00 0 7f800000 81
denorm_exact    0 0 03 000 0 000 000 4000000 00 0 00100000 00
denorm_inexact  0 0 03 000 0 000 000 4000001 00 0 00100000 44
zero_pos        0 0 00 000 0 000 000 0000000 00 0 00000000 08
zero_neg        0 1 00 000 0 000 000 0000000 00 0 80000000 08
zero_lost       0 0 00 000 0 000 000 0000001 00 0 00000000 4c
qnan_neg        0 0 00 000 0 000 07f 4000000 03 0 ffc00000 10
snan            0 0 00 000 0 000 07f 4000000 04 0 7fc00000 30
snan_inv        0 0 00 000 0 000 07f 4000000 14 0 7fc00000 30
invalid_neg     0 1 00 000 0 000 07f 4000000 10 0 ffbfffff 22
inf_in          0 1 00 000 0 000 0ff 4000006 08 0 ff800000 01
flush_a         0 0 00 000 0 000 07f 4000000 00 1 3f800000 00
after_flush     0 0 00 000 0 000 080 6000000 00 0 40400000 00
flush_b0        0 0 00 000 0 000 07f 4000000 00 1 3f800000 00
flush_b1        0 1 00 000 0 000 080 6000000 00 1 c0400000 00
rz_tie          1 0 00 000 0 000 07f 4000004 00 0 3f800000 04
rz_max          1 0 00 000 0 000 07f 7ffffff 00 0 3fffffff 04
rp_tie          2 0 00 000 0 000 07f 4000004 00 0 3f800001 04
rp_exp_carry    2 0 00 000 0 000 07f 7fffff9 00 0 40000000 04
rp_denorm       2 0 03 000 0 000 000 4000001 00 0 00100001 44
rp_zero_lost    2 0 00 000 0 000 000 0000001 00 0 00000001 44
rm_pos          3 0 00 000 0 000 07f 4000004 00 0 3f800000 04
rm_neg          3 1 00 000 0 000 07f 4000006 00 0 bf800001 04

// ==== fpu_rnd_top.f ====
src/fpu_rnd_pkg.sv
src/fpu_align.sv
src/fpu_round.sv
src/fpu_pack.sv
src/fpu_rnd_top.sv
bench/fpu_rnd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fp32 rounding testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module fpu_rnd_tb \
  -f fpu_rnd_top.f -o fpu_rnd_sim
./obj_dir/fpu_rnd_sim > sim.log 2>&1 || true
cat sim.log

if grep -F -q '** FAIL **' sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -F -q '** PASS **' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
